// File: rtl/mcu_cmd_pkg.sv
package mcu_cmd_pkg;

  ////////////////////
  // widths

  localparam int unsigned data_w     = 8;
  localparam int unsigned addr_w     = 24;
  localparam int unsigned mapper_w   = 3;
  // command byte is count 1, first parameter count 2
  localparam int unsigned byte_cnt_w = 8;

  ////////////////////
  // constants and reset values

  localparam logic [data_w-1:0]   signature_byte      = 8'hA5;
  localparam logic [mapper_w-1:0] mapper_reset        = 3'd1;
  // set this feature bit to freeze the address during bulk reads and writes
  localparam int unsigned         feat_no_autoinc_bit = 3;

  ////////////////////
  // command encodings

  // upper nibble of the command byte
  typedef enum logic [3:0] {
    grp_set_addr  = 4'h0,
    grp_rom_mask  = 4'h1,
    grp_sram_mask = 4'h2,
    grp_mapper    = 4'h3,
    grp_mem_read  = 4'h8,
    grp_mem_write = 4'h9,
    grp_ext       = 4'hE,
    grp_sys       = 4'hF
  } cmd_group_e;

  // full-byte commands
  typedef enum logic [7:0] {
    cmd_set_features = 8'hED,
    cmd_set_region   = 8'hEE,
    cmd_signature    = 8'hF0,
    cmd_echo         = 8'hFF
  } cmd_full_e;

  ////////////////////
  // bundles

  typedef struct packed {
    logic                  cmd_ready;
    logic                  param_ready;
    logic [data_w-1:0]     cmd_data;
    logic [data_w-1:0]     param_data;
    logic [byte_cnt_w-1:0] byte_cnt;
  } spi_cmd_t;

  typedef struct packed {
    logic [mapper_w-1:0] mapper;
    logic [addr_w-1:0]   rom_mask;
    logic [addr_w-1:0]   saveram_mask;
    logic [data_w-1:0]   featurebits;
    logic                region;
  } mem_cfg_t;

  typedef struct packed {
    logic              rrq;
    logic              wrq;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } mem_rq_t;

endpackage

// File: rtl/cmd_config_regs.sv
`timescale 1ns/10ps

module cmd_config_regs (
  input  logic                  clk,
  input  logic                  reset,
  input  mcu_cmd_pkg::spi_cmd_t spi,
  output mcu_cmd_pkg::mem_cfg_t cfg
);

  mcu_cmd_pkg::cmd_group_e cmd_group;
  mcu_cmd_pkg::cmd_full_e  cmd_full;

  assign cmd_group = mcu_cmd_pkg::cmd_group_e'(spi.cmd_data[7:4]);
  assign cmd_full  = mcu_cmd_pkg::cmd_full_e'(spi.cmd_data);

  // masks arrive high byte first, one byte per parameter
  function automatic logic [mcu_cmd_pkg::addr_w-1:0] load_mask_byte(
    input logic [mcu_cmd_pkg::addr_w-1:0]     mask,
    input logic [mcu_cmd_pkg::byte_cnt_w-1:0] cnt,
    input logic [mcu_cmd_pkg::data_w-1:0]     data
  );
    logic [mcu_cmd_pkg::addr_w-1:0] res;
    res = mask;
    case (cnt)
      8'd2: res[23:16] = data;
      8'd3: res[15:8]  = data;
      8'd4: res[7:0]   = data;
      default: res = mask;
    endcase
    return res;
  endfunction

  ////////////////////
  // register updates

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.mapper       <= mcu_cmd_pkg::mapper_reset;
      cfg.rom_mask     <= '0;
      cfg.saveram_mask <= '0;
      cfg.featurebits  <= '0;
      cfg.region       <= 1'b0;
    end else if (spi.cmd_ready) begin
      // mapper number rides in the command byte itself
      if (cmd_group == mcu_cmd_pkg::grp_mapper) begin
        cfg.mapper <= spi.cmd_data[mcu_cmd_pkg::mapper_w-1:0];
      end
    end else if (spi.param_ready) begin
      case (cmd_group)
        mcu_cmd_pkg::grp_rom_mask: begin
          cfg.rom_mask <= load_mask_byte(cfg.rom_mask, spi.byte_cnt, spi.param_data);
        end
        mcu_cmd_pkg::grp_sram_mask: begin
          cfg.saveram_mask <= load_mask_byte(cfg.saveram_mask, spi.byte_cnt,
                                             spi.param_data);
        end
        mcu_cmd_pkg::grp_ext: begin
          case (cmd_full)
            mcu_cmd_pkg::cmd_set_features: cfg.featurebits <= spi.param_data;
            mcu_cmd_pkg::cmd_set_region:   cfg.region <= spi.param_data[0];
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  ////////////////////
  // host protocol

  // host sends one byte per strobe, command and parameter never overlap
  a_single_strobe: assert property (
    @(posedge clk) disable iff (reset)
    !(spi.cmd_ready && spi.param_ready)
  );

endmodule

// File: rtl/mem_access_engine.sv
`timescale 1ns/10ps

module mem_access_engine (
  input  logic                               clk,
  input  logic                               reset,
  input  mcu_cmd_pkg::spi_cmd_t              spi,
  input  mcu_cmd_pkg::mem_cfg_t              cfg,
  input  logic [mcu_cmd_pkg::data_w-1:0]     mem_rdata,
  input  logic                               mem_rdy,
  output mcu_cmd_pkg::mem_rq_t               mem_rq,
  output logic                               rd_pulse,
  output logic [mcu_cmd_pkg::data_w-1:0]     rd_data
);

  mcu_cmd_pkg::cmd_group_e cmd_group;

  logic                               rrq_q;
  logic                               wrq_q;
  logic [mcu_cmd_pkg::addr_w-1:0]     addr_q;
  logic [mcu_cmd_pkg::data_w-1:0]     wdata_q;
  logic [1:0]                         rdy_sr;
  logic [mcu_cmd_pkg::data_w-1:0]     rdata_q;
  logic                               next_access;
  logic                               rd_outstanding;
  logic                               access_open;
  logic [mcu_cmd_pkg::byte_cnt_w-1:0] inc_min;
  logic                               inc_en;

  assign cmd_group = mcu_cmd_pkg::cmd_group_e'(spi.cmd_data[7:4]);

  // 1 for plain commands, 2 when bit 4 says the command byte carries no access
  assign inc_min = {{(mcu_cmd_pkg::byte_cnt_w-2){1'b0}}, spi.cmd_data[4], ~spi.cmd_data[4]};

  assign inc_en = (spi.cmd_data[7:5] == 3'b100) && spi.cmd_data[3]
               && (spi.byte_cnt >= inc_min)
               && !cfg.featurebits[mcu_cmd_pkg::feat_no_autoinc_bit];

  ////////////////////
  // request pulses

  always_ff @(posedge clk) begin
    if (reset) begin
      rrq_q <= 1'b0;
      wrq_q <= 1'b0;
    end else begin
      rrq_q <= (spi.cmd_ready || spi.param_ready)
            && (cmd_group == mcu_cmd_pkg::grp_mem_read);
      wrq_q <= spi.param_ready && (cmd_group == mcu_cmd_pkg::grp_mem_write);
    end
  end

  always_ff @(posedge clk) begin
    if (spi.param_ready && cmd_group == mcu_cmd_pkg::grp_mem_write) begin
      wdata_q <= spi.param_data;
    end
  end

  ////////////////////
  // ready edge detect

  always_ff @(posedge clk) begin
    if (reset) begin
      rdy_sr      <= 2'b00;
      next_access <= 1'b0;
    end else begin
      rdy_sr      <= {rdy_sr[0], mem_rdy};
      next_access <= rdy_sr[0] && !rdy_sr[1];
    end
  end

  // memory only guarantees data while ready is up
  always_ff @(posedge clk) begin
    if (mem_rdy) begin
      rdata_q <= mem_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pulse       <= 1'b0;
      rd_outstanding <= 1'b0;
    end else begin
      rd_pulse <= next_access && (cmd_group == mcu_cmd_pkg::grp_mem_read);
      if (rrq_q) begin
        rd_outstanding <= 1'b1;
      end else if (next_access) begin
        rd_outstanding <= 1'b0;
      end
    end
  end

  // any access from its request until memory answers
  always_ff @(posedge clk) begin
    if (reset) begin
      access_open <= 1'b0;
    end else if (rrq_q || wrq_q) begin
      access_open <= 1'b1;
    end else if (mem_rdy) begin
      access_open <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (next_access) begin
      rd_data <= rdata_q;
    end
  end

  ////////////////////
  // address register

  always_ff @(posedge clk) begin
    if (reset) begin
      addr_q <= '0;
    end else if (spi.param_ready && cmd_group == mcu_cmd_pkg::grp_set_addr) begin
      case (spi.byte_cnt)
        8'd2: addr_q <= {spi.param_data, 16'h0000};
        8'd3: addr_q[15:8] <= spi.param_data;
        8'd4: addr_q[7:0] <= spi.param_data;
        default: ;
      endcase
    end else if (next_access && inc_en) begin
      addr_q <= addr_q + mcu_cmd_pkg::addr_w'(1);
    end
  end

  assign mem_rq = '{rrq: rrq_q, wrq: wrq_q, addr: addr_q, wdata: wdata_q};

  // one memory access in flight at a time
  a_one_request: assert property (
    @(posedge clk) disable iff (reset)
    (mem_rq.rrq || mem_rq.wrq) |-> !access_open
  );

  // read data only ever returns for a read that is still open
  a_rd_after_rrq: assert property (
    @(posedge clk) disable iff (reset)
    rd_pulse |-> $past(rd_outstanding)
  );

endmodule

// File: rtl/cmd_readback.sv
`timescale 1ns/10ps

module cmd_readback (
  input  logic                           clk,
  input  logic                           reset,
  input  mcu_cmd_pkg::spi_cmd_t          spi,
  input  logic                           rd_pulse,
  input  logic [mcu_cmd_pkg::data_w-1:0] rd_data,
  output logic [mcu_cmd_pkg::data_w-1:0] spi_data_out
);

  mcu_cmd_pkg::cmd_group_e cmd_group;
  mcu_cmd_pkg::cmd_full_e  cmd_full;
  logic                    strobe;

  assign cmd_group = mcu_cmd_pkg::cmd_group_e'(spi.cmd_data[7:4]);
  assign cmd_full  = mcu_cmd_pkg::cmd_full_e'(spi.cmd_data);
  assign strobe    = spi.cmd_ready || spi.param_ready;

  ////////////////////
  // next byte to host

  always_ff @(posedge clk) begin
    if (reset) begin
      spi_data_out <= '0;
    end else if (rd_pulse) begin
      // memory read result
      spi_data_out <= rd_data;
    end else if (strobe && cmd_group == mcu_cmd_pkg::grp_sys) begin
      case (cmd_full)
        mcu_cmd_pkg::cmd_signature: begin
          spi_data_out <= mcu_cmd_pkg::signature_byte;
        end
        mcu_cmd_pkg::cmd_echo: begin
          // loopback of the byte just received
          if (spi.param_ready) begin
            spi_data_out <= spi.param_data;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// File: rtl/mcu_cmd_top.sv
`timescale 1ns/10ps

module mcu_cmd_top (
  input  logic                           clk,
  input  logic                           reset,
  input  mcu_cmd_pkg::spi_cmd_t          spi,
  input  logic [mcu_cmd_pkg::data_w-1:0] mem_rdata,
  input  logic                           mem_rdy,
  output mcu_cmd_pkg::mem_rq_t           mem_rq,
  output mcu_cmd_pkg::mem_cfg_t          cfg,
  output logic [mcu_cmd_pkg::data_w-1:0] spi_data_out
);

  logic                           rd_pulse;
  logic [mcu_cmd_pkg::data_w-1:0] rd_data;

  ////////////////////
  // config commands

  cmd_config_regs i_cmd_config_regs (
    .clk   (clk),
    .reset (reset),
    .spi   (spi),
    .cfg   (cfg)
  );

  ////////////////////
  // memory side

  // feature bits steer auto-increment in here
  mem_access_engine i_mem_access_engine (
    .clk       (clk),
    .reset     (reset),
    .spi       (spi),
    .cfg       (cfg),
    .mem_rdata (mem_rdata),
    .mem_rdy   (mem_rdy),
    .mem_rq    (mem_rq),
    .rd_pulse  (rd_pulse),
    .rd_data   (rd_data)
  );

  ////////////////////
  // response to host

  cmd_readback i_cmd_readback (
    .clk          (clk),
    .reset        (reset),
    .spi          (spi),
    .rd_pulse     (rd_pulse),
    .rd_data      (rd_data),
    .spi_data_out (spi_data_out)
  );

endmodule

// File: test/sram_model.sv
`timescale 1ns/10ps

module sram_model (
  input  logic                 clk,
  input  logic                 reset,
  input  mcu_cmd_pkg::mem_rq_t mem_rq,
  output logic [7:0]           mem_rdata,
  output logic                 mem_rdy
);

  logic [7:0]  mem [0:65535];
  logic [15:0] addr_q;
  logic [2:0]  delay;
  logic        busy;
  integer      seed = 32'h46c9d650;

  ////////////////////
  // request handling, all on the falling edge

  always @(negedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      delay     <= 3'd0;
      mem_rdy   <= 1'b0;
      mem_rdata <= 8'h00;
    end else begin
      mem_rdy <= 1'b0;
      if (busy) begin
        if (delay == 3'd1) begin
          mem_rdy   <= 1'b1;
          mem_rdata <= mem[addr_q];
          busy      <= 1'b0;
        end else begin
          delay <= delay - 3'd1;
        end
      end else if (mem_rq.rrq || mem_rq.wrq) begin
        addr_q <= mem_rq.addr[15:0];
        busy   <= 1'b1;
        // 1 to 4 cycles until ready
        delay  <= 3'd1 + 3'($random(seed) & 3);
        if (mem_rq.wrq) begin
          mem[mem_rq.addr[15:0]] = mem_rq.wdata;
        end
      end
    end
  end

endmodule

// File: test/tb_mcu_cmd.sv
`timescale 1ns/10ps

module tb_mcu_cmd;

  typedef enum logic [3:0] {
    cfg_mapper, cfg_rom_mask, cfg_saveram_mask, cfg_featurebits, cfg_region,
    rq_rrq, rq_wrq, rq_addr, rq_wdata, out_data, sram_mem
  } sig_e;

  typedef struct packed {
    sig_e        sig;
    logic [23:0] addr;
    logic [23:0] value;
  } check_t;

  logic                  clk = 1'b0;
  logic                  reset;
  mcu_cmd_pkg::spi_cmd_t spi;
  logic [7:0]            mem_rdata;
  logic                  mem_rdy;
  mcu_cmd_pkg::mem_rq_t  mem_rq;
  mcu_cmd_pkg::mem_cfg_t cfg;
  logic [7:0]            spi_data_out;

  logic [7:0]  shadow [0:65535];
  check_t      checks [0:63];
  event        check_ev;
  int          wr_ptr = 0;
  int          rd_ptr = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          n_failed_tests = 0;
  int          errors_at_start = 0;
  logic        aborted = 1'b0;
  logic        run_done = 1'b0;
  logic [23:0] exp_addr = 24'd0;
  logic [7:0]  exp_feat = 8'd0;

  always #2 clk = ~clk;

  mcu_cmd_top i_mcu_cmd_top (
    .clk          (clk),
    .reset        (reset),
    .spi          (spi),
    .mem_rdata    (mem_rdata),
    .mem_rdy      (mem_rdy),
    .mem_rq       (mem_rq),
    .cfg          (cfg),
    .spi_data_out (spi_data_out)
  );

  sram_model i_sram_model (
    .clk       (clk),
    .reset     (reset),
    .mem_rq    (mem_rq),
    .mem_rdata (mem_rdata),
    .mem_rdy   (mem_rdy)
  );

  ////////////////////
  // reference model

  function automatic logic [7:0] ref_mem_init(input logic [15:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h5A;
  endfunction

  function automatic void ref_mem_write(input logic [15:0] a, input logic [7:0] d);
    shadow[a] = d;
  endfunction

  // bulk commands step the address once per access
  function automatic logic [23:0] ref_next_addr(input logic [23:0] a, input logic [7:0] cmd,
                                                input logic [7:0] cnt, input logic [7:0] feat);
    logic bulk_group;
    bulk_group = (cmd[7:4] == 4'h8) || (cmd[7:4] == 4'h9);
    if (bulk_group && cmd[3] && cnt >= 8'd1 + 8'(cmd[4])
        && !feat[mcu_cmd_pkg::feat_no_autoinc_bit]) begin
      return a + 24'd1;
    end
    return a;
  endfunction

  function automatic logic [23:0] sample(input sig_e sig, input logic [23:0] a);
    case (sig)
      cfg_mapper:       return 24'(cfg.mapper);
      cfg_rom_mask:     return cfg.rom_mask;
      cfg_saveram_mask: return cfg.saveram_mask;
      cfg_featurebits:  return 24'(cfg.featurebits);
      cfg_region:       return 24'(cfg.region);
      rq_rrq:           return 24'(mem_rq.rrq);
      rq_wrq:           return 24'(mem_rq.wrq);
      rq_addr:          return mem_rq.addr;
      rq_wdata:         return 24'(mem_rq.wdata);
      out_data:         return 24'(spi_data_out);
      default:          return 24'(i_sram_model.mem[a[15:0]]);
    endcase
  endfunction

  ////////////////////
  // checking

  always @(check_ev) begin : compare
    check_t      c;
    sig_e        s;
    logic [23:0] actual;
    while (rd_ptr != wr_ptr) begin
      c = checks[6'(rd_ptr)];
      s = c.sig;
      actual = sample(s, c.addr);
      n_checks = n_checks + 1;
      if (actual !== c.value) begin
        $display("Mismatch %s: expected 0x%0h, got 0x%0h", s.name(), c.value, actual);
        n_errors = n_errors + 1;
      end
      rd_ptr = rd_ptr + 1;
    end
  end

  task automatic expect_val(input sig_e sig, input logic [23:0] value,
                            input logic [23:0] addr = 24'd0);
    checks[6'(wr_ptr)] = '{sig: sig, addr: addr, value: value};
    wr_ptr = wr_ptr + 1;
    -> check_ev;
  endtask

  task automatic stall(input string reason);
    $display("%s", reason);
    aborted = 1'b1;
    // parked until the watchdog ends the run
    forever @(posedge clk);
  endtask

  task automatic end_test(input string name);
    int n;
    n = 0;
    while (rd_ptr != wr_ptr) begin
      if (n == 10) stall("checks were not processed within 10 cycles");
      @(negedge clk);
      n = n + 1;
    end
    if (n_errors == errors_at_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d mismatches", name, n_errors - errors_at_start);
      n_failed_tests = n_failed_tests + 1;
    end
    errors_at_start = n_errors;
  endtask

  ////////////////////
  // host and memory handshakes

  task automatic send_byte(input logic is_cmd, input logic [7:0] data);
    @(negedge clk);
    if (is_cmd) begin
      spi.cmd_data  = data;
      spi.byte_cnt  = 8'd1;
      spi.cmd_ready = 1'b1;
    end else begin
      spi.param_data  = data;
      spi.byte_cnt    = spi.byte_cnt + 8'd1;
      spi.param_ready = 1'b1;
    end
    @(negedge clk);
    spi.cmd_ready   = 1'b0;
    spi.param_ready = 1'b0;
  endtask

  task automatic send_three(input logic [7:0] cmd, input logic [23:0] p);
    send_byte(1'b1, cmd);
    send_byte(1'b0, p[23:16]);
    send_byte(1'b0, p[15:8]);
    send_byte(1'b0, p[7:0]);
  endtask

  // ready pulse, then ready pipeline, increment and readback register
  task automatic wait_access();
    int n;
    n = 0;
    do begin
      if (n == 20) stall("memory gave no ready pulse within 20 cycles");
      @(posedge clk);
      n = n + 1;
    end while (!mem_rdy);
    repeat (3) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic read_byte(input logic is_cmd, input logic [7:0] data);
    send_byte(is_cmd, data);
    expect_val(rq_rrq, 24'd1);
    expect_val(rq_addr, exp_addr);
    wait_access();
    expect_val(out_data, 24'(shadow[exp_addr[15:0]]));
    exp_addr = ref_next_addr(exp_addr, spi.cmd_data, spi.byte_cnt, exp_feat);
    expect_val(rq_addr, exp_addr);
  endtask

  task automatic write_byte(input logic [7:0] data);
    send_byte(1'b0, data);
    expect_val(rq_wrq, 24'd1);
    expect_val(rq_addr, exp_addr);
    expect_val(rq_wdata, 24'(data));
    ref_mem_write(exp_addr[15:0], data);
    wait_access();
    expect_val(sram_mem, 24'(shadow[exp_addr[15:0]]), exp_addr);
    exp_addr = ref_next_addr(exp_addr, spi.cmd_data, spi.byte_cnt, exp_feat);
    expect_val(rq_addr, exp_addr);
  endtask

  ////////////////////
  // stimulus

  initial begin : stimulus
    int i;
    spi   = '0;
    reset = 1'b1;
    for (i = 0; i < 65536; i = i + 1) begin
      shadow[16'(i)] = ref_mem_init(16'(i));
      i_sram_model.mem[16'(i)] = shadow[16'(i)];
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    expect_val(cfg_mapper, 24'(mcu_cmd_pkg::mapper_reset));
    expect_val(cfg_rom_mask, 24'd0);
    expect_val(cfg_saveram_mask, 24'd0);
    expect_val(cfg_featurebits, 24'd0);
    expect_val(cfg_region, 24'd0);
    expect_val(rq_rrq, 24'd0);
    expect_val(rq_wrq, 24'd0);
    expect_val(out_data, 24'd0);
    end_test("reset values");

    send_byte(1'b1, 8'h35);
    expect_val(cfg_mapper, 24'(8'h35 & 8'h07));
    send_three(8'h10, 24'h123456);
    expect_val(cfg_rom_mask, 24'h123456);
    send_three(8'h20, 24'h001FFF);
    expect_val(cfg_saveram_mask, 24'h001FFF);
    send_byte(1'b1, 8'hED);
    send_byte(1'b0, 8'h00);
    exp_feat = 8'h00;
    expect_val(cfg_featurebits, 24'(exp_feat));
    send_byte(1'b1, 8'hEE);
    send_byte(1'b0, 8'h01);
    expect_val(cfg_region, 24'd1);
    end_test("configuration writes");

    send_three(8'h00, 24'h000120);
    exp_addr = 24'h000120;
    expect_val(rq_addr, exp_addr);
    read_byte(1'b1, 8'h88);
    repeat (4) read_byte(1'b0, 8'h00);
    expect_val(rq_addr, 24'h000125);
    end_test("incrementing read");

    send_three(8'h00, 24'h000200);
    exp_addr = 24'h000200;
    send_byte(1'b1, 8'h98);
    write_byte(8'hC3);
    write_byte(8'h5E);
    write_byte(8'h91);
    expect_val(rq_addr, 24'h000203);
    send_three(8'h00, 24'h000200);
    exp_addr = 24'h000200;
    // bit 3 clear, address must stay put
    read_byte(1'b1, 8'h80);
    end_test("incrementing write");

    send_byte(1'b1, 8'hED);
    send_byte(1'b0, 8'h08);
    exp_feat = 8'h08;
    expect_val(cfg_featurebits, 24'(exp_feat));
    read_byte(1'b1, 8'h88);
    read_byte(1'b0, 8'h00);
    read_byte(1'b0, 8'h00);
    expect_val(rq_addr, 24'h000200);
    end_test("feature gate");

    send_byte(1'b1, 8'hF0);
    expect_val(out_data, 24'hA5);
    send_byte(1'b1, 8'hFF);
    send_byte(1'b0, 8'h3C);
    expect_val(out_data, 24'h3C);
    end_test("signature and echo");

    run_done = 1'b1;
  end

  initial begin : watchdog
    int n;
    n = 0;
    while (!run_done && !aborted && n < 5000) begin
      @(posedge clk);
      n = n + 1;
    end
    if (!run_done && !aborted) begin
      $display("run did not complete within 5000 cycles");
    end
    $display("tests 6, failed %0d, checks %0d, mismatches %0d",
             n_failed_tests, n_checks, n_errors);
    if (run_done && n_errors == 0 && n_failed_tests == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
rtl/mcu_cmd_pkg.sv
rtl/cmd_config_regs.sv
rtl/mem_access_engine.sv
rtl/cmd_readback.sv
rtl/mcu_cmd_top.sv
test/sram_model.sv
test/tb_mcu_cmd.sv

// File: run_sim.sh
#!/bin/bash
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_mcu_cmd -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_mcu_cmd)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
